// ==== dv/fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

    localparam int CACHE_LINES   = 32;
    localparam int MEM_LATENCY   = 6;
    localparam int MEM_BLOCKS    = 256;
    localparam int LOAD_BITS     = $clog2(MEM_BLOCKS);
    localparam int STREAM_BLOCKS = 40;

    // Fetches over all tests: cold, re-hit, conflict, stall, abandoned, stream
    localparam int TOTAL_FETCHES = 1 + 1 + 4 + 1 + 2 + STREAM_BLOCKS;
    localparam int CYCLE_LIMIT   = 40 * TOTAL_FETCHES + 200 + MEM_BLOCKS + 3;  // Preload, reset

    localparam icache_pkg::addr_t COLD_ADDR    = 32'h0000_0120;  // Line 4
    localparam icache_pkg::addr_t CONFLICT_A   = 32'h0000_0340;  // Line 8, tag 3
    localparam icache_pkg::addr_t CONFLICT_B   = 32'h0000_0440;  // Line 8, tag 4
    localparam icache_pkg::addr_t STALL_ADDR   = 32'h0000_0580;  // Line 16
    localparam icache_pkg::addr_t ABANDON_ADDR = 32'h0000_0700;  // Line 0, tag 7
    localparam icache_pkg::addr_t REPLACE_ADDR = 32'h0000_0808;  // Line 1, tag 8
    localparam icache_pkg::addr_t STREAM_ADDR  = 32'h0000_1000;

    logic                       clock, reset;
    logic                       redirect, stall, load_en;
    icache_pkg::addr_t          redirect_addr, fetch_addr;
    logic [LOAD_BITS-1:0]       load_index;
    icache_pkg::mem_block_t     load_data, insn_block;
    logic                       insn_valid;

    icache_pkg::mem_block_t     mem_copy [MEM_BLOCKS];  // Shadow of the preloaded memory
    integer                     seed = 32'h5159_dbd4;

    int checks = 0, compare_errors = 0;         // Comparison process only
    int test_checks = 0, errors = 0;            // Test sequence only
    int tests = 0, errors_at_start = 0;
    int cycle_count = 0;
    int cycles, stall_cycles;

    fetch_top #(
        .CACHE_LINES(CACHE_LINES),
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_BLOCKS (MEM_BLOCKS)
    ) uut (
        .clock        (clock),
        .reset        (reset),
        .redirect     (redirect),
        .redirect_addr(redirect_addr),
        .stall        (stall),
        .load_en      (load_en),
        .load_index   (load_index),
        .load_data    (load_data),
        .insn_block   (insn_block),
        .insn_valid   (insn_valid),
        .fetch_addr   (fetch_addr)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;     // 40 ns period
    end

    ////////////////////////////////////////////////////////////
    // Reference and comparison
    ////////////////////////////////////////////////////////////

    // Block number from address bits 15:3, wrapped on memory depth
    function automatic icache_pkg::mem_block_t expected_block(input icache_pkg::addr_t addr);
        int unsigned          block_no;
        logic [LOAD_BITS-1:0] index;
        block_no = 32'(addr[15:3]);
        index    = LOAD_BITS'(block_no % MEM_BLOCKS);
        return mem_copy[index];
    endfunction

    always @(negedge clock) begin
        if (!reset && insn_valid) begin
            checks++;
            assert (insn_block == expected_block(fetch_addr))
            else begin
                compare_errors++;
                $display("[ERROR] %0t: block at %h: expected %h, found %h", $time,
                         fetch_addr, expected_block(fetch_addr), insn_block);
            end
        end
    end

    // Watchdog
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: fetch stalled, no finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic preload_memory();
        logic [LOAD_BITS-1:0] index;
        logic [31:0]          rand_word;
        for (int i = 0; i < MEM_BLOCKS; i++) begin
            index           = LOAD_BITS'(i);
            rand_word       = $random(seed);
            mem_copy[index] = {rand_word, rand_word ^ (32'(i) * 32'h9e37_79b9)};
            @(posedge clock);
            load_en    <= 1'b1;
            load_index <= index;
            load_data  <= mem_copy[index];
        end
        @(posedge clock);
        load_en <= 1'b0;
        stall   <= 1'b0;    // Memory open to the cache
    endtask

    task automatic redirect_to(input icache_pkg::addr_t addr);
        @(posedge clock);
        redirect      <= 1'b1;
        redirect_addr <= addr;
        @(posedge clock);
        redirect      <= 1'b0;  // fetch_addr shows addr from here on
    endtask

    // Cycles from the address change until insn_valid, 0 for a hit
    task automatic wait_fetch(output int count);
        count = 0;
        @(negedge clock);
        while (!insn_valid) begin
            count++;
            @(negedge clock);
        end
    endtask

    task automatic check_cycles(input string what, input int count, input int lo, input int hi);
        test_checks++;
        assert (count >= lo && count <= hi)
        else begin
            errors++;
            $display("[ERROR] %0t: %s took %0d cycles, expected %0d to %0d", $time,
                     what, count, lo, hi);
        end
    endtask

    task automatic finish_test(input string name);
        int failed;
        @(posedge clock);   // Last negedge comparison has landed
        failed = errors + compare_errors - errors_at_start;
        tests++;
        if (failed == 0) begin
            $display("Test %0d %s: passed", tests, name);
        end else begin
            $display("Test %0d %s: failed, %0d errors", tests, name, failed);
        end
        errors_at_start = errors + compare_errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset         <= 1'b1;
        redirect      <= 1'b0;
        redirect_addr <= '0;
        stall         <= 1'b1;  // No fills until memory holds its data
        load_en       <= 1'b0;
        load_index    <= '0;
        load_data     <= '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        preload_memory();

        redirect_to(COLD_ADDR);
        wait_fetch(cycles);
        check_cycles("cold miss", cycles, 1, MEM_LATENCY + 2);
        finish_test("cold miss");

        redirect_to(COLD_ADDR);     // Line still resident
        wait_fetch(cycles);
        check_cycles("re-hit", cycles, 0, 0);
        finish_test("re-hit");

        for (int visit = 0; visit < 4; visit++) begin
            redirect_to(visit % 2 == 0 ? CONFLICT_A : CONFLICT_B);
            wait_fetch(cycles);
            check_cycles("conflict fetch", cycles, visit < 2 ? 1 : 2, MEM_LATENCY + 2);
        end
        finish_test("conflict");

        stall_cycles = 3 + int'($unsigned($random(seed)) % 32'd8);
        @(posedge clock);
        redirect      <= 1'b1;
        redirect_addr <= STALL_ADDR;
        stall         <= 1'b1;
        @(posedge clock);
        redirect <= 1'b0;
        repeat (stall_cycles) @(posedge clock);
        stall <= 1'b0;
        wait_fetch(cycles);
        check_cycles("stalled miss", stall_cycles + cycles, stall_cycles + 1,
                     MEM_LATENCY + 2 + stall_cycles);
        finish_test("stall");

        @(posedge clock);
        redirect      <= 1'b1;
        redirect_addr <= ABANDON_ADDR;
        @(posedge clock);
        redirect <= 1'b0;
        repeat (2) @(posedge clock);        // Tag accepted, now WAITING
        redirect      <= 1'b1;
        redirect_addr <= REPLACE_ADDR;
        @(posedge clock);
        redirect <= 1'b0;
        wait_fetch(cycles);
        check_cycles("replacing miss", cycles, 1, MEM_LATENCY + 2);
        redirect_to(ABANDON_ADDR);          // Never filled, so a miss again
        wait_fetch(cycles);
        check_cycles("abandoned address revisit", cycles, 1, MEM_LATENCY + 2);
        finish_test("abandoned miss");

        redirect_to(STREAM_ADDR);
        for (int k = 0; k < STREAM_BLOCKS; k++) begin
            wait_fetch(cycles);
            test_checks++;
            assert (fetch_addr == STREAM_ADDR + icache_pkg::addr_t'(k * 8))
            else begin
                errors++;
                $display("[ERROR] %0t: stream block %0d at %h, expected address %h", $time,
                         k, fetch_addr, STREAM_ADDR + icache_pkg::addr_t'(k * 8));
            end
        end
        finish_test("streaming");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks + test_checks,
                 errors + compare_errors);
        if (errors + compare_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/icache_props.sv ====
`timescale 1ns/10ps
`default_nettype none

// Protocol checks on the instruction cache
module icache_props #(
    parameter int CACHE_LINES = 32
) (
    input wire logic                            clock,
    input wire logic                            reset,
    input wire icache_pkg::mem_req_t            mem_req,
    input wire icache_pkg::mem_rsp_t            mem_rsp,
    input wire logic                            hit,
    input wire logic [$clog2(CACHE_LINES)-1:0]  cur_index
);

    logic [CACHE_LINES-1:0]           filled;         // Lines whose data came back
    icache_pkg::mem_tag_t             accepted_tag;   // Last tag memory handed out
    logic [$clog2(CACHE_LINES)-1:0]   accepted_line;  // Line that load was for
    logic                             accepted;       // Load taken this cycle

    assign accepted = (mem_req.command == icache_pkg::MEM_LOAD)
                      && (mem_rsp.transaction_tag != '0);

    // Fills as seen on the memory bus
    always_ff @(posedge clock) begin
        if (reset) begin
            filled       <= '0;
            accepted_tag <= '0;
        end else begin
            if (accepted) begin
                accepted_tag  <= mem_rsp.transaction_tag;
                accepted_line <= cur_index;
            end
            if (accepted_tag != '0 && mem_rsp.data_tag == accepted_tag) begin
                filled[accepted_line] <= 1'b1;  // Data cycle of that load
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Properties
    ////////////////////////////////////////////////////////////

    mem_idle_after_reset: assert property (
        @(posedge clock) reset |=> mem_req.command == icache_pkg::MEM_NONE
    ) else $error("memory load issued right after reset");

    // A held tag is never asked for again
    no_load_while_waiting: assert property (
        @(posedge clock) disable iff (reset)
        accepted |=> mem_req.command != icache_pkg::MEM_LOAD
    ) else $error("memory load repeated after its tag was accepted");

    hit_only_on_filled_line: assert property (
        @(posedge clock) disable iff (reset) hit |-> filled[cur_index]
    ) else $error("hit on a line never filled since reset");

endmodule

bind icache icache_props #(
    .CACHE_LINES(CACHE_LINES)
) props (
    .clock    (clock),
    .reset    (reset),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .hit      (hit),
    .cur_index(cur_index)
);

`default_nettype wire

// ==== hdl/fetch_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

// Fetch address register
// Steps one block per hit, jumps on redirect, holds on a miss
module fetch_sequencer (
    input  wire logic               clock,
    input  wire logic               reset,

    // Outside control
    input  wire logic               redirect,       // Load redirect_addr at the edge
    input  wire icache_pkg::addr_t  redirect_addr,

    // Cache
    input  wire logic               hit,            // Current block delivered
    output icache_pkg::addr_t       fetch_addr      // Always block aligned
);

    icache_pkg::addr_t next_addr;
    icache_pkg::addr_t target_addr;    // Redirect target with the offset cleared
    icache_pkg::addr_t step_addr;      // Following block

    ////////////////////////////////////////////////////////////
    // Next address
    ////////////////////////////////////////////////////////////

    assign target_addr = redirect_addr & ~icache_pkg::OFFSET_MASK;
    assign step_addr   = fetch_addr + icache_pkg::addr_t'(icache_pkg::BLOCK_BYTES);

    always_comb begin
        if (redirect) begin
            next_addr = target_addr;    // Redirect wins over a hit
        end else if (hit) begin
            next_addr = step_addr;
        end else begin
            next_addr = fetch_addr;     // Miss in progress
        end
    end

    ////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_addr <= '0;           // Start of memory
        end else begin
            fetch_addr <= next_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// Fetch subsystem
// Sequencer feeds the cache, cache misses go to the tagged memory
module fetch_top #(
    parameter int CACHE_LINES = 32,
    parameter int MEM_LATENCY = 6,
    parameter int MEM_BLOCKS  = 256
) (
    input  wire logic                           clock,
    input  wire logic                           reset,

    input  wire logic                           redirect,
    input  wire icache_pkg::addr_t              redirect_addr,
    input  wire logic                           stall,

    input  wire logic                           load_en,     // Memory preload
    input  wire logic [$clog2(MEM_BLOCKS)-1:0]  load_index,
    input  wire icache_pkg::mem_block_t         load_data,

    output icache_pkg::mem_block_t              insn_block,
    output logic                                insn_valid,  // Also the sequencer step
    output icache_pkg::addr_t                   fetch_addr
);

    icache_pkg::mem_req_t mem_req;
    icache_pkg::mem_rsp_t mem_rsp;

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    fetch_sequencer sequencer (
        .clock        (clock),
        .reset        (reset),
        .redirect     (redirect),
        .redirect_addr(redirect_addr),
        .hit          (insn_valid),
        .fetch_addr   (fetch_addr)
    );

    icache #(
        .CACHE_LINES(CACHE_LINES)
    ) cache (
        .clock     (clock),
        .reset     (reset),
        .fetch_addr(fetch_addr),
        .block     (insn_block),
        .hit       (insn_valid),
        .mem_rsp   (mem_rsp),
        .mem_req   (mem_req)
    );

    tagged_mem #(
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_BLOCKS (MEM_BLOCKS)
    ) memory (
        .clock     (clock),
        .reset     (reset),
        .stall     (stall),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .load_en   (load_en),
        .load_index(load_index),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

// ==== hdl/icache.sv ====
`timescale 1ns/10ps
`default_nettype none

// Blocking direct-mapped instruction cache
// One miss at a time, abandoned when the fetch address moves
module icache #(
    parameter int CACHE_LINES = 32
) (
    input  wire logic                   clock,
    input  wire logic                   reset,

    // Fetch side
    input  wire icache_pkg::addr_t      fetch_addr,
    output icache_pkg::mem_block_t      block,      // Line for fetch_addr
    output logic                        hit,        // block is valid

    // Memory side
    input  wire icache_pkg::mem_rsp_t   mem_rsp,
    output icache_pkg::mem_req_t        mem_req
);

    localparam int INDEX_BITS = $clog2(CACHE_LINES);
    localparam int TAG_BITS   = icache_pkg::CACHE_ADDR_HI - icache_pkg::OFFSET_BITS + 1
                                - INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   line_tag_t;     // Cache tag, not a memory tag

    index_t                   cur_index, last_index;
    line_tag_t                cur_tag,   last_tag;
    logic [CACHE_LINES-1:0]   line_valid;
    line_tag_t                line_tag [CACHE_LINES];

    icache_pkg::cache_state_e state, state_next;
    icache_pkg::mem_tag_t     held_tag, held_tag_next;   // Tag of the pending load

    logic changed_addr;
    logic got_data;
    logic fill;

    ////////////////////////////////////////////////////////////
    // Address split and lookup
    ////////////////////////////////////////////////////////////

    assign {cur_tag, cur_index} =
        fetch_addr[icache_pkg::CACHE_ADDR_HI:icache_pkg::OFFSET_BITS];

    assign hit = line_valid[cur_index] && (line_tag[cur_index] == cur_tag);

    assign changed_addr = (cur_index != last_index) || (cur_tag != last_tag);

    // Data for our tag, never for an address already left behind
    assign got_data = (state == icache_pkg::WAITING) && (mem_rsp.data_tag == held_tag);
    assign fill     = got_data && !changed_addr;

    icache_data_ram #(
        .WIDTH($bits(icache_pkg::mem_block_t)),
        .DEPTH(CACHE_LINES)
    ) data_ram (
        .clock(clock),
        .raddr(cur_index),
        .rdata(block),
        .we   (fill),
        .waddr(cur_index),
        .wdata(mem_rsp.data)
    );

    ////////////////////////////////////////////////////////////
    // Miss FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next    = state;
        held_tag_next = held_tag;
        if (changed_addr) begin
            // Fresh decision, any old tag is dropped
            state_next    = hit ? icache_pkg::IDLE : icache_pkg::REQUESTING;
            held_tag_next = '0;
        end else begin
            case (state)
                icache_pkg::IDLE: begin
                    if (!hit) begin
                        state_next = icache_pkg::REQUESTING;
                    end
                end
                icache_pkg::REQUESTING: begin
                    if (mem_rsp.transaction_tag != '0) begin  // Accepted
                        state_next    = icache_pkg::WAITING;
                        held_tag_next = mem_rsp.transaction_tag;
                    end
                end
                icache_pkg::WAITING: begin
                    if (fill) begin
                        state_next    = icache_pkg::IDLE;  // hit rises next cycle
                        held_tag_next = '0;
                    end
                end
                default: state_next = icache_pkg::IDLE;
            endcase
        end
    end

    // Load repeats until memory hands out a tag
    always_comb begin
        mem_req.command = (state == icache_pkg::REQUESTING && !changed_addr) ?
                          icache_pkg::MEM_LOAD : icache_pkg::MEM_NONE;
        mem_req.addr    = fetch_addr & ~icache_pkg::OFFSET_MASK;  // Block aligned
    end

    ////////////////////////////////////////////////////////////
    // State registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            last_index <= '1;   // All ones so the first address counts as a change
            last_tag   <= '1;
            state      <= icache_pkg::IDLE;
            held_tag   <= '0;
            line_valid <= '0;
        end else begin
            last_index <= cur_index;
            last_tag   <= cur_tag;
            state      <= state_next;
            held_tag   <= held_tag_next;
            if (fill) begin
                line_valid[cur_index] <= 1'b1;
            end
        end
    end

    // Tag array, guarded by line_valid
    always_ff @(posedge clock) begin
        if (fill) begin
            line_tag[cur_index] <= cur_tag;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/icache_data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

// Line storage of the instruction cache
// Read is combinational, write lands on the clock edge
module icache_data_ram #(
    parameter int WIDTH = $bits(icache_pkg::mem_block_t),
    parameter int DEPTH = 32
) (
    input  wire logic                       clock,

    // Read port
    input  wire logic [$clog2(DEPTH)-1:0]   raddr,
    output icache_pkg::mem_block_t          rdata,

    // Write port
    input  wire logic                       we,
    input  wire logic [$clog2(DEPTH)-1:0]   waddr,
    input  wire icache_pkg::mem_block_t     wdata
);

    logic [WIDTH-1:0] mem [DEPTH];  // Line array

    ////////////////////////////////////////////////////////////
    // Write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;    // Fill from memory
        end
    end

    ////////////////////////////////////////////////////////////
    // Read
    ////////////////////////////////////////////////////////////

    // A write in this cycle shows up on the next one
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== hdl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    ////////////////////////////////////////////////////////////
    // Address and block geometry
    ////////////////////////////////////////////////////////////

    localparam int OFFSET_BITS   = 3;                 // Byte offset inside one block
    localparam int BLOCK_BYTES   = 1 << OFFSET_BITS;  // 8-byte memory block
    localparam int CACHE_ADDR_HI = 15;                // Top address bit seen by the cache

    typedef logic [31:0] addr_t;        // Byte address
    typedef logic [63:0] mem_block_t;   // One memory block
    typedef logic [3:0]  mem_tag_t;     // Memory transaction tag, 0 means none

    // Clears the byte offset of an address
    localparam addr_t OFFSET_MASK = addr_t'(BLOCK_BYTES - 1);

    ////////////////////////////////////////////////////////////
    // Memory bus
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,    // Idle bus
        MEM_LOAD = 2'd1     // Block read
    } mem_command_e;

    // Cache to memory
    typedef struct packed {
        mem_command_e command;
        addr_t        addr;     // Block aligned
    } mem_req_t;

    // Memory to cache
    typedef struct packed {
        mem_tag_t   transaction_tag;  // Same cycle as the request, 0 if refused
        mem_block_t data;             // Valid only with a nonzero data_tag
        mem_tag_t   data_tag;         // Tag of the returning transaction
    } mem_rsp_t;

    ////////////////////////////////////////////////////////////
    // Cache miss tracking
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE       = 2'd0,  // Hit, or nothing to do
        REQUESTING = 2'd1,  // Repeating MEM_LOAD until a tag comes back
        WAITING    = 2'd2   // Holding the tag until the data returns
    } cache_state_e;

endpackage

`default_nettype wire

// ==== hdl/tagged_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

// Tagged multi-cycle memory model
// Tag issued in the request cycle, data MEM_LATENCY cycles later
module tagged_mem #(
    parameter int MEM_LATENCY = 6,      // 2 to 14, stays below the tag count
    parameter int MEM_BLOCKS  = 256     // Depth in blocks, power of two
) (
    input  wire logic                           clock,
    input  wire logic                           reset,

    input  wire logic                           stall,      // Higher priority user
    input  wire icache_pkg::mem_req_t           mem_req,
    output icache_pkg::mem_rsp_t                mem_rsp,

    // Preload port
    input  wire logic                           load_en,
    input  wire logic [$clog2(MEM_BLOCKS)-1:0]  load_index,
    input  wire icache_pkg::mem_block_t         load_data
);

    localparam int INDEX_BITS = $clog2(MEM_BLOCKS);

    typedef logic [INDEX_BITS-1:0] block_index_t;

    localparam icache_pkg::mem_tag_t TAG_FIRST = 4'd1;
    localparam icache_pkg::mem_tag_t TAG_LAST  = '1;

    icache_pkg::mem_block_t blocks [MEM_BLOCKS];    // Backing store

    icache_pkg::mem_tag_t   next_tag;               // Tag for the next accepted load
    icache_pkg::mem_tag_t   pipe_tag   [MEM_LATENCY];
    block_index_t           pipe_index [MEM_LATENCY];

    logic                   accept;
    block_index_t           req_index;
    icache_pkg::mem_tag_t   out_tag;

    ////////////////////////////////////////////////////////////
    // Request side
    ////////////////////////////////////////////////////////////

    assign accept    = (mem_req.command == icache_pkg::MEM_LOAD) && !stall;
    assign req_index = mem_req.addr[icache_pkg::OFFSET_BITS +: INDEX_BITS];  // Wraps on depth

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= TAG_FIRST;
        end else if (accept) begin
            next_tag <= (next_tag == TAG_LAST) ? TAG_FIRST : next_tag + 4'd1;  // Skip 0
        end
    end

    ////////////////////////////////////////////////////////////
    // Return pipeline
    ////////////////////////////////////////////////////////////

    // Tags in flight, one slot per cycle of latency
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            pipe_tag[0] <= accept ? next_tag : '0;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
        end
    end

    // Block indexes ride alongside, meaningful only with a nonzero tag
    always_ff @(posedge clock) begin
        pipe_index[0] <= req_index;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            pipe_index[i] <= pipe_index[i-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // Store and response
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (load_en) begin
            blocks[load_index] <= load_data;
        end
    end

    assign out_tag = pipe_tag[MEM_LATENCY-1];

    always_comb begin
        mem_rsp.transaction_tag = accept ? next_tag : '0;    // 0 means refused
        mem_rsp.data_tag        = out_tag;
        mem_rsp.data            = (out_tag != '0) ? blocks[pipe_index[MEM_LATENCY-1]] : '0;
    end

endmodule

`default_nettype wire

// ==== icache_fetch.f ====
hdl/icache_pkg.sv
hdl/icache_data_ram.sv
hdl/icache.sv
hdl/fetch_sequencer.sv
hdl/tagged_mem.sv
hdl/fetch_top.sv
dv/icache_props.sv
dv/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module fetch_tb -f icache_fetch.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vfetch_tb > sim.log 2>&1
cat sim.log

grep -qx "No errors" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
